// File: include/rmw_cfg.svh
// ==========================================================
// Build-time sizing for the read-modify-write shim
// RMW_SLOTS must be at least 2, and its index must fit below
// the reserved top bit of the request tag
// Lines are whole; there are no multi-beat requests
// ==========================================================

`ifndef RMW_CFG_SVH
`define RMW_CFG_SVH

// Bytes carried by one line, and so bits in a byte mask
`define RMW_LINE_BYTES 16

// Width of a line address
`define RMW_ADDR_BITS 32

// Width of the request tag. The top bit is reserved for read-for-modify
`define RMW_MDATA_BITS 8

// Number of partial writes that may wait for their old line at once
`define RMW_SLOTS 4

// Write input buffer depth and the free-entry level that raises almost-full
`define RMW_IN_DEPTH 8
`define RMW_IN_THRESHOLD 4

`endif

// File: hw/rmw_pkg.sv
// ==========================================================
// Shared types for the read-modify-write shim
// All request and response structs carry their own valid bit
// The top mdata bit is reserved for shim-generated reads
// ==========================================================

`include "rmw_cfg.svh"

package rmw_pkg;

    // Slot index width and the reserved tag bit position
    localparam int SLOT_BITS = $clog2(`RMW_SLOTS);
    localparam int TAG_BIT = `RMW_MDATA_BITS - 1;

    typedef logic [`RMW_LINE_BYTES*8-1:0] line_t;
    typedef logic [`RMW_LINE_BYTES-1:0] mask_t;
    typedef logic [`RMW_ADDR_BITS-1:0] addr_t;
    typedef logic [`RMW_MDATA_BITS-1:0] mdata_t;
    typedef logic [SLOT_BITS-1:0] slot_t;

    // Read request, used toward memory and from the accelerator
    typedef struct packed {
        logic valid;
        addr_t addr;
        mdata_t mdata;
    } rd_req_t;

    // Read response, one whole line
    typedef struct packed {
        logic valid;
        mdata_t mdata;
        line_t data;
    } rd_rsp_t;

    // Write request. A mask of all ones marks a full-line write
    typedef struct packed {
        logic valid;
        addr_t addr;
        line_t data;
        mask_t mask;
        mdata_t mdata;
    } wr_req_t;

    // Read-for-modify request from the write side to the read side
    typedef struct packed {
        logic valid;
        addr_t addr;
        slot_t slot;
    } inject_t;

    // Old line returned for a parked slot
    typedef struct packed {
        logic valid;
        slot_t slot;
        line_t data;
    } merge_t;

endpackage

// File: hw/rmw_fifo.sv
// ==========================================================
// Synchronous FIFO with a type-parameter payload
// The head entry is visible on first while not_empty is high
// Callers must not enqueue when full or dequeue when empty
// almost_full is high while free entries <= THRESHOLD
// ==========================================================

module rmw_fifo
#(
    parameter type payload_t = logic,
    parameter int DEPTH = 4,
    parameter int THRESHOLD = 1
)
(
    input  logic clk,
    input  logic reset,

    input  logic enq_en,
    input  payload_t enq_data,
    output logic almost_full,

    output payload_t first,
    input  logic deq_en,
    output logic not_empty
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    // Storage array of DEPTH entries
    payload_t mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (deq_en)
        begin
            rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end

        // The occupancy moves only when exactly one side is active
        if (enq_en && !deq_en)
        begin
            count <= count + 1'b1;
        end
        else if (deq_en && !enq_en)
        begin
            count <= count - 1'b1;
        end

        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
    end

    assign first = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign almost_full = ((CNT_BITS'(DEPTH) - count) <= CNT_BITS'(THRESHOLD));

endmodule

// File: hw/rmw_write_port.sv
// ==========================================================
// Write side of the shim
// Full writes pass to memory; partial writes leave the queue
// only when a slot is free and the read side grants a read
// Full writes may overtake writes parked in the slot table
// A merged write has priority over the queue head
// ==========================================================

`include "rmw_cfg.svh"

module rmw_write_port
(
    input  logic clk,
    input  logic reset,

    input  rmw_pkg::wr_req_t afu_wr_req,
    output logic afu_wr_almost_full,

    output rmw_pkg::wr_req_t mem_wr_req,
    input  logic mem_wr_almost_full,

    output rmw_pkg::inject_t inject,
    input  logic inject_grant,

    input  logic slot_free,
    input  rmw_pkg::slot_t free_slot,

    output logic park,
    output rmw_pkg::wr_req_t park_req,

    input  rmw_pkg::wr_req_t done_req,
    output logic done_take,

    output logic head_partial
);

    import rmw_pkg::*;

    // ============================================================
    // Input buffer
    // ============================================================

    wr_req_t head;
    logic head_valid;
    logic head_deq;
    logic full_deq;

    rmw_fifo
    #(
        .payload_t(wr_req_t),
        .DEPTH(`RMW_IN_DEPTH),
        .THRESHOLD(`RMW_IN_THRESHOLD)
    )
    in_fifo
    (
        .clk,
        .reset,
        .enq_en(afu_wr_req.valid),
        .enq_data(afu_wr_req),
        .almost_full(afu_wr_almost_full),
        .first(head),
        .deq_en(head_deq),
        .not_empty(head_valid)
    );

    // The head is partial when any byte of its mask is clear
    assign head_partial = head_valid && (head.mask != '1);

    // ============================================================
    // Head dispatch
    // ============================================================

    // Ask the read side for a read-for-modify only when a slot can hold the write
    assign inject.valid = head_partial && slot_free;
    assign inject.addr = head.addr;
    assign inject.slot = free_slot;

    assign park = inject.valid && inject_grant;

    always_comb
    begin
        park_req = head;
        park_req.valid = park;
    end

    // Merged writes go first, and nothing is issued while memory is almost full
    assign done_take = done_req.valid && !mem_wr_almost_full;
    assign full_deq = head_valid && !head_partial && !mem_wr_almost_full && !done_req.valid;

    assign head_deq = full_deq || park;

    // Registered memory write port
    always_ff @(posedge clk)
    begin
        if (done_take)
        begin
            mem_wr_req <= done_req;
        end
        else
        begin
            mem_wr_req <= head;
        end
        mem_wr_req.valid <= done_take || full_deq;

        if (reset)
        begin
            mem_wr_req.valid <= 1'b0;
        end
    end

endmodule

// File: hw/rmw_slot_table.sv
// ==========================================================
// Slot table for parked partial writes
// A slot is claimed by park and released by done_take
// Merged slots are queued in response order
// Only one park and one merge may happen per cycle
// ==========================================================

`include "rmw_cfg.svh"

module rmw_slot_table
(
    input  logic clk,
    input  logic reset,

    input  logic park,
    input  rmw_pkg::wr_req_t park_req,

    output logic slot_free,
    output rmw_pkg::slot_t free_slot,

    input  rmw_pkg::merge_t merge,

    output rmw_pkg::wr_req_t done_req,
    input  logic done_take
);

    import rmw_pkg::*;

    // Busy bit per slot, plus the parked write with its new bytes and mask
    logic [`RMW_SLOTS-1:0] busy;
    wr_req_t slot_req [`RMW_SLOTS];

    slot_t done_slot;
    logic done_valid;
    line_t merged_line;

    // ============================================================
    // Free slot search
    // ============================================================

    // Lowest numbered idle slot wins
    always_comb
    begin
        free_slot = '0;
        for (int i = `RMW_SLOTS - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                free_slot = slot_t'(i);
            end
        end
    end

    assign slot_free = !(&busy);

    // ============================================================
    // Merge of new bytes over the returned line
    // ============================================================

    // Bytes set in the parked mask come from the write, the others from memory
    always_comb
    begin
        for (int b = 0; b < `RMW_LINE_BYTES; b++)
        begin
            merged_line[b*8 +: 8] = slot_req[merge.slot].mask[b] ?
                                    slot_req[merge.slot].data[b*8 +: 8] :
                                    merge.data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (park)
        begin
            slot_req[free_slot] <= park_req;
        end
        if (merge.valid)
        begin
            slot_req[merge.slot].data <= merged_line;
        end
    end

    // Park and release always name different slots
    always_ff @(posedge clk)
    begin
        if (park)
        begin
            busy[free_slot] <= 1'b1;
        end
        if (done_take)
        begin
            busy[done_slot] <= 1'b0;
        end

        if (reset)
        begin
            busy <= '0;
        end
    end

    // ============================================================
    // Done queue
    // ============================================================

    // Holds at most every slot once, so it never overflows
    rmw_fifo
    #(
        .payload_t(slot_t),
        .DEPTH(`RMW_SLOTS),
        .THRESHOLD(1)
    )
    done_fifo
    (
        .clk,
        .reset,
        .enq_en(merge.valid),
        .enq_data(merge.slot),
        .almost_full(),
        .first(done_slot),
        .deq_en(done_take),
        .not_empty(done_valid)
    );

    // The finished line now covers every byte
    always_comb
    begin
        done_req = slot_req[done_slot];
        done_req.mask = '1;
        done_req.valid = done_valid;
    end

endmodule

// File: hw/rmw_read_port.sv
// ==========================================================
// Read side of the shim
// Accelerator reads pass through in the same cycle
// Accelerator reads must keep the top mdata bit clear
// Tagged responses are consumed here and never forwarded
// ==========================================================

module rmw_read_port
(
    input  logic clk,
    input  logic reset,

    input  rmw_pkg::rd_req_t afu_rd_req,
    output rmw_pkg::rd_rsp_t afu_rd_rsp,
    output logic afu_rd_almost_full,

    output rmw_pkg::rd_req_t mem_rd_req,
    input  rmw_pkg::rd_rsp_t mem_rd_rsp,
    input  logic mem_rd_almost_full,

    input  rmw_pkg::inject_t inject,
    output logic inject_grant,

    input  logic head_partial,

    output rmw_pkg::merge_t merge
);

    import rmw_pkg::*;

    logic ready_q;
    logic partial_wait_q;
    logic rsp_tagged;

    // ============================================================
    // Requests
    // ============================================================

    // Ready follows memory almost-full with one cycle of delay
    always_ff @(posedge clk)
    begin
        ready_q <= !mem_rd_almost_full;
        partial_wait_q <= head_partial;

        if (reset)
        begin
            ready_q <= 1'b0;
            partial_wait_q <= 1'b0;
        end
    end

    // Hold off the accelerator for a cycle so a waiting partial write gets a free slot
    assign afu_rd_almost_full = mem_rd_almost_full || partial_wait_q;

    // An injected read uses only a cycle with no accelerator read
    assign inject_grant = inject.valid && !afu_rd_req.valid && !mem_rd_almost_full && ready_q;

    always_comb
    begin
        mem_rd_req = afu_rd_req;
        if (inject_grant)
        begin
            mem_rd_req.valid = 1'b1;
            mem_rd_req.addr = inject.addr;
            mem_rd_req.mdata = '0;
            mem_rd_req.mdata[TAG_BIT] = 1'b1;
            mem_rd_req.mdata[SLOT_BITS-1:0] = inject.slot;
        end
    end

    // ============================================================
    // Responses
    // ============================================================

    assign rsp_tagged = mem_rd_rsp.mdata[TAG_BIT];

    always_comb
    begin
        afu_rd_rsp = mem_rd_rsp;
        afu_rd_rsp.valid = mem_rd_rsp.valid && !rsp_tagged;
    end

    // Tagged lines go to the slot table one cycle later
    always_ff @(posedge clk)
    begin
        merge.valid <= mem_rd_rsp.valid && rsp_tagged;
        merge.slot <= mem_rd_rsp.mdata[SLOT_BITS-1:0];
        merge.data <= mem_rd_rsp.data;

        if (reset)
        begin
            merge.valid <= 1'b0;
        end
    end

endmodule

// File: hw/rmw_shim.sv
// ==========================================================
// Read-modify-write shim top level
// Emulates byte-masked writes on a full-line memory port
// Back-pressure is by almost-full levels only
// Write order between different lines is not kept
// ==========================================================

module rmw_shim
(
    input  logic clk,
    input  logic reset,

    input  rmw_pkg::rd_req_t afu_rd_req,
    output rmw_pkg::rd_rsp_t afu_rd_rsp,
    output logic afu_rd_almost_full,

    input  rmw_pkg::wr_req_t afu_wr_req,
    output logic afu_wr_almost_full,

    output rmw_pkg::rd_req_t mem_rd_req,
    input  rmw_pkg::rd_rsp_t mem_rd_rsp,
    input  logic mem_rd_almost_full,

    output rmw_pkg::wr_req_t mem_wr_req,
    input  logic mem_wr_almost_full
);

    import rmw_pkg::*;

    // Read-for-modify handshake between the write and read sides
    inject_t inject;
    logic inject_grant;
    logic head_partial;

    // Slot table traffic
    logic slot_free;
    slot_t free_slot;
    logic park;
    wr_req_t park_req;
    merge_t merge;
    wr_req_t done_req;
    logic done_take;

    rmw_write_port write_port
    (
        .clk,
        .reset,
        .afu_wr_req,
        .afu_wr_almost_full,
        .mem_wr_req,
        .mem_wr_almost_full,
        .inject,
        .inject_grant,
        .slot_free,
        .free_slot,
        .park,
        .park_req,
        .done_req,
        .done_take,
        .head_partial
    );

    rmw_slot_table slot_table
    (
        .clk,
        .reset,
        .park,
        .park_req,
        .slot_free,
        .free_slot,
        .merge,
        .done_req,
        .done_take
    );

    rmw_read_port read_port
    (
        .clk,
        .reset,
        .afu_rd_req,
        .afu_rd_rsp,
        .afu_rd_almost_full,
        .mem_rd_req,
        .mem_rd_rsp,
        .mem_rd_almost_full,
        .inject,
        .inject_grant,
        .head_partial,
        .merge
    );

endmodule

// File: bench/rmw_mem_model.sv
// ==========================================================
// Behavioral line memory for the shim testbench
// Unwritten lines read back as a pattern of their address
// Reads are answered in order 3 cycles after the request
// Old data is captured when the read request is seen
// With random_bp high both almost-full outputs flicker
// ==========================================================

`include "rmw_cfg.svh"

module rmw_mem_model
(
    input  logic clk,
    input  logic reset,
    input  logic random_bp,

    input  rmw_pkg::rd_req_t mem_rd_req,
    output rmw_pkg::rd_rsp_t mem_rd_rsp,
    output logic mem_rd_almost_full,

    input  rmw_pkg::wr_req_t mem_wr_req,
    output logic mem_wr_almost_full
);

    timeunit 1ns;
    timeprecision 100ps;

    import rmw_pkg::*;

    localparam int READ_DELAY = 3;

    // Lines written so far, all others still hold their initial pattern
    line_t lines [addr_t];

    // Responses waiting to be returned, with the cycle each one is due
    rd_rsp_t pend_rsp [$];
    longint pend_due [$];
    longint cycle;
    integer seed = 32'h3716_74f6;

    // Each byte mixes one byte of the address with its byte position
    function automatic line_t initial_line(addr_t addr);
        line_t value;
        for (int b = 0; b < `RMW_LINE_BYTES; b++)
        begin
            value[b*8 +: 8] = addr[(b % 4) * 8 +: 8] ^ 8'(b * 29 + 8'h5a);
        end
        return value;
    endfunction

    // Current contents of a line, also used by the testbench
    function automatic line_t peek_line(addr_t addr);
        if (lines.exists(addr))
        begin
            return lines[addr];
        end
        return initial_line(addr);
    endfunction

    initial
    begin
        mem_rd_rsp = '0;
        mem_rd_almost_full = 1'b0;
        mem_wr_almost_full = 1'b0;
        cycle = 0;
    end

    always @(posedge clk)
    begin
        rd_rsp_t rsp;
        line_t wline;
        rsp = '0;
        if (reset)
        begin
            pend_rsp.delete();
            pend_due.delete();
            cycle = 0;
            mem_rd_rsp <= '0;
            mem_rd_almost_full <= 1'b0;
            mem_wr_almost_full <= 1'b0;
        end
        else
        begin
            cycle++;
            // A read sees the line as it was before a write in the same cycle
            if (mem_rd_req.valid)
            begin
                rsp.valid = 1'b1;
                rsp.mdata = mem_rd_req.mdata;
                rsp.data = peek_line(mem_rd_req.addr);
                pend_rsp.push_back(rsp);
                pend_due.push_back(cycle + READ_DELAY);
            end
            // Only bytes with their mask bit set are stored
            if (mem_wr_req.valid)
            begin
                wline = peek_line(mem_wr_req.addr);
                for (int b = 0; b < `RMW_LINE_BYTES; b++)
                begin
                    if (mem_wr_req.mask[b])
                    begin
                        wline[b*8 +: 8] = mem_wr_req.data[b*8 +: 8];
                    end
                end
                lines[mem_wr_req.addr] = wline;
            end
            if (pend_due.size() > 0 && pend_due[0] == cycle)
            begin
                mem_rd_rsp <= pend_rsp.pop_front();
                void'(pend_due.pop_front());
            end
            else
            begin
                mem_rd_rsp <= '0;
            end
            // Roughly one cycle in four is blocked on each side
            mem_rd_almost_full <= random_bp && (($random(seed) & 3) == 0);
            mem_wr_almost_full <= random_bp && (($random(seed) & 3) == 0);
        end
    end

endmodule

// File: bench/rmw_shim_tb.sv
// ==========================================================
// Directed testbench for the read-modify-write shim
// Writes to different lines may reach memory in any order
// Accelerator reads keep the top mdata bit clear
// Every wait gives up after TIMEOUT cycles
// ==========================================================

`include "rmw_cfg.svh"

module rmw_shim_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rmw_pkg::*;

    localparam int TIMEOUT = 400;
    localparam int MIXED_WRITES = 2 * `RMW_SLOTS + 2;

    logic clk;
    logic reset;
    logic random_bp;

    rd_req_t afu_rd_req;
    rd_rsp_t afu_rd_rsp;
    logic afu_rd_almost_full;
    wr_req_t afu_wr_req;
    logic afu_wr_almost_full;
    rd_req_t mem_rd_req;
    rd_rsp_t mem_rd_rsp;
    logic mem_rd_almost_full;
    wr_req_t mem_wr_req;
    logic mem_wr_almost_full;

    // Writes seen at the memory port and responses seen by the accelerator
    wr_req_t wr_log [$];
    rd_rsp_t rsp_log [$];
    // Responses owed to the accelerator in issue order
    rd_rsp_t exp_rsp [$];

    integer seed = 32'h3716_74f6;
    int error_count = 0;

    rmw_shim dut0
    (
        .clk,
        .reset,
        .afu_rd_req,
        .afu_rd_rsp,
        .afu_rd_almost_full,
        .afu_wr_req,
        .afu_wr_almost_full,
        .mem_rd_req,
        .mem_rd_rsp,
        .mem_rd_almost_full,
        .mem_wr_req,
        .mem_wr_almost_full
    );

    rmw_mem_model mem0
    (
        .clk,
        .reset,
        .random_bp,
        .mem_rd_req,
        .mem_rd_rsp,
        .mem_rd_almost_full,
        .mem_wr_req,
        .mem_wr_almost_full
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // ============================================================
    // Error reporting and helpers
    // ============================================================

    task automatic report_mismatch(input string test, input line_t expected, input line_t actual);
        error_count++;
        $display("CHECK FAILED in %s: expected %h, actual %h", test, expected, actual);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_test(input string what);
        error_count++;
        $display("ERROR: %s", what);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    // Bytes with a set mask bit come from the new line and the rest stay as they were
    function automatic line_t merge_bytes(line_t old_line, line_t new_line, mask_t mask);
        line_t result;
        for (int b = 0; b < `RMW_LINE_BYTES; b++)
        begin
            result[b*8 +: 8] = mask[b] ? new_line[b*8 +: 8] : old_line[b*8 +: 8];
        end
        return result;
    endfunction

    function automatic line_t random_line();
        line_t value;
        for (int w = 0; w < `RMW_LINE_BYTES / 4; w++)
        begin
            value[w*32 +: 32] = $random(seed);
        end
        return value;
    endfunction

    // Sampled on the edge where registered and driven values are settled
    always @(posedge clk)
    begin
        if (mem_wr_req.valid)
        begin
            wr_log.push_back(mem_wr_req);
        end
        if (afu_rd_rsp.valid)
        begin
            assert (!afu_rd_rsp.mdata[TAG_BIT])
            else abort_test("a tagged read response reached the accelerator");
            rsp_log.push_back(afu_rd_rsp);
        end
    end

    // ============================================================
    // Stimulus tasks
    // ============================================================

    task automatic issue_read(input string test, input addr_t addr, input mdata_t mdata);
        int cycles;
        rd_rsp_t exp;
        cycles = 0;
        @(posedge clk);
        #1;
        while (afu_rd_almost_full)
        begin
            cycles++;
            if (cycles > TIMEOUT)
            begin
                abort_test("the read port stayed almost full");
            end
            @(posedge clk);
            #1;
        end
        afu_rd_req.valid = 1'b1;
        afu_rd_req.addr = addr;
        afu_rd_req.mdata = mdata;
        exp.valid = 1'b1;
        exp.mdata = mdata;
        exp.data = mem0.peek_line(addr);
        exp_rsp.push_back(exp);
        // The read must already be on the memory port in this cycle
        #1;
        assert (mem_rd_req.valid) else report_mismatch(test, 1, mem_rd_req.valid);
        assert (mem_rd_req.addr == addr && mem_rd_req.mdata == mdata)
        else report_mismatch(test, line_t'({addr, mdata}),
                             line_t'({mem_rd_req.addr, mem_rd_req.mdata}));
        @(posedge clk);
        #1;
        afu_rd_req.valid = 1'b0;
    endtask

    task automatic issue_write(input addr_t addr, input line_t data, input mask_t mask,
                               input mdata_t mdata);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        while (afu_wr_almost_full)
        begin
            cycles++;
            if (cycles > TIMEOUT)
            begin
                abort_test("the write port stayed almost full");
            end
            @(posedge clk);
            #1;
        end
        afu_wr_req.valid = 1'b1;
        afu_wr_req.addr = addr;
        afu_wr_req.data = data;
        afu_wr_req.mask = mask;
        afu_wr_req.mdata = mdata;
        @(posedge clk);
        #1;
        afu_wr_req.valid = 1'b0;
    endtask

    // Takes the logged memory write to one line out of the log
    task automatic wait_for_write(input addr_t addr, output wr_req_t seen);
        int cycles;
        bit found;
        cycles = 0;
        found = 1'b0;
        while (!found)
        begin
            @(posedge clk);
            #1;
            for (int i = 0; i < wr_log.size() && !found; i++)
            begin
                if (wr_log[i].addr == addr)
                begin
                    seen = wr_log[i];
                    wr_log.delete(i);
                    found = 1'b1;
                end
            end
            cycles++;
            if (!found && cycles > TIMEOUT)
            begin
                abort_test($sformatf("no memory write arrived for line %h", addr));
            end
        end
    endtask

    // Checks a written line, its full mask, its tag and the memory contents
    task automatic check_write(input string test, input addr_t addr, input line_t data,
                               input mdata_t mdata);
        wr_req_t seen;
        wait_for_write(addr, seen);
        assert (seen.data == data) else report_mismatch(test, data, seen.data);
        assert (seen.mask == '1) else report_mismatch(test, line_t'(mask_t'('1)), seen.mask);
        assert (seen.mdata == mdata) else report_mismatch(test, mdata, seen.mdata);
        assert (mem0.peek_line(addr) == data)
        else report_mismatch(test, data, mem0.peek_line(addr));
    endtask

    // Responses come back in issue order, and each read gets exactly one
    task automatic check_responses(input string test);
        int cycles;
        rd_rsp_t exp;
        rd_rsp_t act;
        cycles = 0;
        while (rsp_log.size() < exp_rsp.size())
        begin
            cycles++;
            if (cycles > TIMEOUT)
            begin
                abort_test($sformatf("%0d read responses are missing",
                                     exp_rsp.size() - rsp_log.size()));
            end
            @(posedge clk);
            #1;
        end
        while (exp_rsp.size() > 0)
        begin
            exp = exp_rsp.pop_front();
            act = rsp_log.pop_front();
            assert (act.mdata == exp.mdata) else report_mismatch(test, exp.mdata, act.mdata);
            assert (act.data == exp.data) else report_mismatch(test, exp.data, act.data);
        end
        // A short quiet period to catch duplicate responses
        repeat (8)
        begin
            @(posedge clk);
        end
        #1;
        assert (rsp_log.size() == 0) else report_mismatch(test, 0, rsp_log.size());
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic check_reset_state();
        assert (!mem_wr_req.valid) else report_mismatch("reset_state", 0, mem_wr_req.valid);
        assert (!mem_rd_req.valid) else report_mismatch("reset_state", 0, mem_rd_req.valid);
        assert (!afu_wr_almost_full) else report_mismatch("reset_state", 0, afu_wr_almost_full);
        assert (!afu_rd_almost_full) else report_mismatch("reset_state", 0, afu_rd_almost_full);
    endtask

    task automatic test_read_passthrough();
        for (int i = 0; i < 4; i++)
        begin
            issue_read("read_passthrough", addr_t'(32'h0000_1000 + i * 32'h0101_0011),
                       mdata_t'(i + 3));
        end
        check_responses("read_passthrough");
    endtask

    task automatic test_full_write();
        addr_t addr;
        line_t data;
        addr = addr_t'(32'h8000_0040);
        data = random_line();
        issue_write(addr, data, '1, mdata_t'(8'h21));
        check_write("full_write", addr, data, mdata_t'(8'h21));
    endtask

    task automatic test_partial_write();
        addr_t addr;
        line_t data;
        mask_t mask;
        line_t merged;
        addr = addr_t'(32'h0456_7890);
        data = random_line();
        mask = mask_t'($random(seed));
        mask[0] = 1'b0;
        mask[1] = 1'b1;
        merged = merge_bytes(mem0.peek_line(addr), data, mask);
        issue_write(addr, data, mask, mdata_t'(8'h3c));
        // The partial head of the last cycle holds the accelerator reads off now
        @(posedge clk);
        #1;
        assert (afu_rd_almost_full) else report_mismatch("partial_write", 1, afu_rd_almost_full);
        check_write("partial_write", addr, merged, mdata_t'(8'h3c));
        // The read for modify must stay hidden from the accelerator
        assert (rsp_log.size() == 0) else report_mismatch("partial_write", 0, rsp_log.size());
    endtask

    task automatic test_mixed_traffic();
        addr_t addrs [MIXED_WRITES];
        line_t merged [MIXED_WRITES];
        mdata_t tags [MIXED_WRITES];
        line_t data;
        mask_t mask;
        random_bp = 1'b1;
        // More partial writes than slots with a read of another line after each
        for (int i = 0; i < MIXED_WRITES; i++)
        begin
            addrs[i] = addr_t'(32'h00a0_0000 + i * 32'h0001_0003);
            data = random_line();
            mask = mask_t'($random(seed));
            mask[i % `RMW_LINE_BYTES] = 1'b0;
            tags[i] = mdata_t'(i + 8'h40);
            merged[i] = merge_bytes(mem0.peek_line(addrs[i]), data, mask);
            issue_write(addrs[i], data, mask, tags[i]);
            issue_read("mixed_traffic", addr_t'(32'h0b00_0000 + i * 32'h10), mdata_t'(i));
        end
        for (int i = 0; i < MIXED_WRITES; i++)
        begin
            check_write("mixed_traffic", addrs[i], merged[i], tags[i]);
        end
        check_responses("mixed_traffic");
        random_bp = 1'b0;
    endtask

    initial
    begin
        reset = 1'b1;
        random_bp = 1'b0;
        afu_rd_req = '0;
        afu_wr_req = '0;
        repeat (10)
        begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;

        check_reset_state();
        test_read_passthrough();
        test_full_write();
        test_partial_write();
        test_mixed_traffic();

        if (error_count == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: Bender.yml
package:
  name: rmw_shim

sources:
  - include_dirs:
      - include
    files:
      - hw/rmw_pkg.sv
      - hw/rmw_fifo.sv
      - hw/rmw_write_port.sv
      - hw/rmw_slot_table.sv
      - hw/rmw_read_port.sv
      - hw/rmw_shim.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/rmw_mem_model.sv
      - bench/rmw_shim_tb.sv

// File: rmw_shim.f
+incdir+include
hw/rmw_pkg.sv
hw/rmw_fifo.sv
hw/rmw_write_port.sv
hw/rmw_slot_table.sv
hw/rmw_read_port.sv
hw/rmw_shim.sv
bench/rmw_mem_model.sv
bench/rmw_shim_tb.sv
